//--- rtl/mem_pkg.sv
// shared constants and record types for the memory access stage
// every rtl module of the stage pulls these in by a wildcard import
package mem_pkg;

    localparam int data_w    = 32;
    localparam int rd_w      = 5;
    localparam int ram_words = 256;
    localparam int ram_aw    = $clog2(ram_words);   // word index bits, taken from addr[9:2]
    localparam int exp_w     = 7;
    localparam int exp_ale   = 2;                   // address alignment exception bit

    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } width_e;

    // instruction record coming from execute
    typedef struct packed {
        logic              en;      // memory op
        logic              write;
        logic              atom;    // ll / sc
        logic              sign;    // sign extend loads
        width_e            width;
        logic [rd_w-1:0]   rd;
        logic [data_w-1:0] base;
        logic [data_w-1:0] imm;
        logic [data_w-1:0] wdata;
        logic [exp_w-1:0]  exp;
    } exe_mem_t;

    // request into the data ram
    typedef struct packed {
        logic              valid;
        logic              op;      // 1 = write
        logic              atom;
        logic [data_w-1:0] addr;
        logic [3:0]        be;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    // response from the data ram
    typedef struct packed {
        logic              data_valid;  // one cycle pulse
        logic [data_w-1:0] rdata;
        logic [exp_w-1:0]  exception;
        logic [data_w-1:0] badv;
    } mem_rsp_t;

    // what the response half keeps of the op while the ram works
    typedef struct packed {
        logic             valid;    // entry present
        logic             en;
        logic             write;
        logic             atom;
        logic             sign;
        width_e           width;
        logic [rd_w-1:0]  rd;
        logic [1:0]       addr_lo;
        logic [exp_w-1:0] exp;
    } mem_hold_t;

    // writeback record
    typedef struct packed {
        logic              valid;
        logic [rd_w-1:0]   rd;
        logic [data_w-1:0] data;
        logic [exp_w-1:0]  exp;
        logic [data_w-1:0] badv;
    } wb_t;

    // one read word, seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage

//--- rtl/load_align.sv
// load aligner, picks the addressed byte or halfword out of a read word
// and extends it to a full register value
module load_align import mem_pkg::*; (
    input  logic [data_w-1:0] rdata,
    input  logic [1:0]        addr_lo,
    input  width_e            width,
    input  logic              sign,
    output logic [data_w-1:0] data
);

    load_word_u  word;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign word   = rdata;
    assign lane_b = word.bytes[addr_lo];
    assign lane_h = word.halves[addr_lo[1]];   // half is aligned, bit 0 is zero

    always_comb begin
        case (width)
            width_byte: data = {{(data_w-8){sign && lane_b[7]}}, lane_b};
            width_half: data = {{(data_w-16){sign && lane_h[15]}}, lane_h};
            default:    data = rdata;          // word passes unchanged
        endcase
    end

endmodule

//--- rtl/mem_request.sv
// request half of the memory stage
// turns the execute record into a ram request plus the state kept for the response
module mem_request import mem_pkg::*; (
    input  exe_mem_t  exe,
    output mem_req_t  req,
    output mem_hold_t hold_next
);

    logic [data_w-1:0] addr;
    logic [3:0]        be_base;     // lanes before the address offset
    logic [7:0]        be_dbl;
    logic [data_w-1:0] wdata_lanes;

    assign addr = exe.base + exe.imm;

    // lane pattern and store data replicated over every lane
    always_comb begin
        case (exe.width)
            width_byte: begin
                be_base     = 4'b0001;
                wdata_lanes = {4{exe.wdata[7:0]}};
            end
            width_half: begin
                be_base     = 4'b0011;
                wdata_lanes = {2{exe.wdata[15:0]}};
            end
            default: begin
                be_base     = 4'b1111;
                wdata_lanes = exe.wdata;
            end
        endcase
    end

    // rotate rather than shift so the lane count survives a misaligned offset,
    // the ram decodes the access size from it
    assign be_dbl = {be_base, be_base} << addr[1:0];

    always_comb begin
        req.valid = exe.en;
        req.op    = exe.write;
        req.atom  = exe.atom;
        req.addr  = addr;
        req.be    = be_dbl[7:4];
        req.wdata = wdata_lanes;
        if (req.valid) begin
            assert (req.be != 4'b0000)
                else $error("mem_request: valid request without byte enables");
        end
    end

    always_comb begin
        hold_next.valid   = exe.en || (exe.rd != '0);  // memory op or something to write back
        hold_next.en      = exe.en;
        hold_next.write   = exe.write;
        hold_next.atom    = exe.atom;
        hold_next.sign    = exe.sign;
        hold_next.width   = exe.width;
        hold_next.rd      = exe.rd;
        hold_next.addr_lo = addr[1:0];
        hold_next.exp     = exe.exp;
    end

endmodule

//--- rtl/data_ram.sv
// behavioral data memory with address dependent latency and one ll/sc reservation
// one request in flight; a new one is taken when idle or in the completion cycle
module data_ram import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    logic [data_w-1:0] mem [ram_words];

    mem_req_t          lat;         // request being served
    logic              busy;
    logic [1:0]        cnt;         // cycles left before completion
    logic              mis;         // latched request was misaligned
    logic              resv_valid;
    logic [ram_aw-1:0] resv_idx;

    logic              accept;
    logic              done;
    logic              req_word;
    logic              req_half;
    logic              req_mis;
    logic [ram_aw-1:0] lat_idx;
    logic              sc_ok;
    logic              do_write;

    // access size recovered from the lane count
    assign req_word = (req.be == 4'b1111);
    assign req_half = ($countones(req.be) == 2);
    assign req_mis  = (req_word && req.addr[1:0] != 2'b00) || (req_half && req.addr[0]);

    assign done     = busy && (cnt == 2'd0);
    assign accept   = req.valid && (!busy || done);
    assign lat_idx  = lat.addr[ram_aw+1:2];
    assign sc_ok    = resv_valid && (resv_idx == lat_idx);
    assign do_write = lat.op && !mis && (!lat.atom || sc_ok);

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= 2'd0;
            mis        <= 1'b0;
            resv_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                cnt  <= req_mis ? 2'd0 : req.addr[3:2];   // misaligned reports next cycle
                mis  <= req_mis;
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 2'd1;
            end

            if (done && !mis) begin
                if (!lat.op && lat.atom) begin
                    resv_valid <= 1'b1;                   // ll
                end else if (lat.op && lat.atom) begin
                    resv_valid <= 1'b0;                   // sc, pass or fail
                end else if (lat.op && lat_idx == resv_idx) begin
                    resv_valid <= 1'b0;
                end
            end
        end
    end

    // storage and latched payload
    always_ff @(posedge clk) begin
        if (accept) begin
            lat <= req;
        end
        if (done && !mis && !lat.op && lat.atom) begin
            resv_idx <= lat_idx;
        end
        if (done && do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (lat.be[i]) begin
                    mem[lat_idx][8*i +: 8] <= lat.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp = '0;
        if (done) begin
            if (mis) begin
                rsp.exception[exp_ale] = 1'b1;
                rsp.badv               = lat.addr;
            end else begin
                rsp.data_valid = 1'b1;
                // sc answers with its success flag
                rsp.rdata      = (lat.op && lat.atom) ? {{(data_w-1){1'b0}}, sc_ok}
                                                      : mem[lat_idx];
            end
        end
    end

    // a completion lands exactly the address latency after its request was taken
    assert property (@(posedge clk) disable iff (rst)
        rsp.data_valid |->
            ($past(accept, 1) && $past(req.addr[3:2], 1) == 2'd0) ||
            ($past(accept, 2) && $past(req.addr[3:2], 2) == 2'd1) ||
            ($past(accept, 3) && $past(req.addr[3:2], 3) == 2'd2) ||
            ($past(accept, 4) && $past(req.addr[3:2], 4) == 2'd3))
        else $error("data_ram: data_valid without a request taken at the matching latency");

endmodule

//--- rtl/mem_response.sv
// response half of the memory stage
// waits for the ram, raises the stall and builds the writeback record
module mem_response import mem_pkg::*; (
    input  mem_hold_t hold,
    input  mem_rsp_t  rsp,
    output wb_t       wb,
    output logic      stall
);

    logic [data_w-1:0] load_data;
    logic [exp_w-1:0]  exp_all;
    logic              ram_done;
    logic              has_exp;

    load_align u_align (
        .rdata   (rsp.rdata),
        .addr_lo (hold.addr_lo),
        .width   (hold.width),
        .sign    (hold.sign),
        .data    (load_data)
    );

    assign ram_done = rsp.data_valid || (rsp.exception != '0);
    assign stall    = hold.en && !ram_done;      // held memory op still in the ram
    assign exp_all  = hold.exp | rsp.exception;
    assign has_exp  = (exp_all != '0);

    always_comb begin
        wb       = '0;
        wb.valid = hold.valid && !stall;
        wb.exp   = exp_all;
        wb.rd    = has_exp ? '0 : hold.rd;
        if (hold.en && rsp.data_valid) begin
            if (!hold.write) begin
                wb.data = load_data;
            end else if (hold.atom) begin
                wb.data = rsp.rdata;             // sc flag
            end
        end
        if (hold.en && has_exp) begin
            wb.badv = rsp.badv;
        end
        // the ram either completes or faults, never both
        if (wb.valid) begin
            assert (!(rsp.data_valid && rsp.exception != '0))
                else $error("mem_response: data_valid together with an exception");
        end
    end

endmodule

//--- rtl/mem_stage_top.sv
// memory access stage, request half and data ram feeding the response half
// execute record in, writeback record and global stall out
module mem_stage_top import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  exe_mem_t exe,
    output wb_t      wb,
    output logic     stall
);

    mem_req_t  req;
    mem_rsp_t  rsp;
    mem_hold_t hold_next;
    mem_hold_t hold;        // op waiting on the ram

    mem_request u_request (
        .exe       (exe),
        .req       (req),
        .hold_next (hold_next)
    );

    data_ram u_ram (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    // stage register between the two halves, frozen while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            hold <= '0;
        end else if (!stall) begin
            hold <= hold_next;
        end
    end

    mem_response u_response (
        .hold  (hold),
        .rsp   (rsp),
        .wb    (wb),
        .stall (stall)
    );

    // longest ram latency is four cycles, so a stall always clears within that
    assert property (@(posedge clk) disable iff (rst)
        stall |-> ##[1:4] !stall)
        else $error("mem_stage_top: stall held longer than the ram latency");

endmodule

//--- testbench/tb_mem_stage.sv
// testbench for the memory access stage, a reference model of the ram and ll/sc
// predicts every writeback record and concurrent assertions compare them
module tb_mem_stage import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        wb_t        wb;
        logic [2:0] stalls;     // stall cycles before completion
    } exp_rec_t;

    logic     clk = 1'b0;
    logic     rst;
    exe_mem_t exe;
    wb_t      wb;
    logic     stall;

    logic [data_w-1:0] model_mem [ram_words];
    logic              resv_v;
    logic [ram_aw-1:0] resv_idx;
    logic [31:0]       lcg_state;
    exe_mem_t          ops_q [$];
    exp_rec_t          exp_q [$];

    exp_rec_t   exp_head;
    logic       head_ok;
    logic       checking;
    wb_t        wb_seen;
    logic       stall_seen;
    logic [2:0] stall_cnt;
    logic [2:0] seen_stalls;
    logic       started;       // first op applied
    int         errors;
    int         wb_count;
    int         cycles = 0;
    int         limit;

    mem_stage_top uut (
        .clk   (clk),
        .rst   (rst),
        .exe   (exe),
        .wb    (wb),
        .stall (stall)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // starting contents, distinct for every word address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr + 32'd4) * 32'h9e3779b9;
    endfunction

    function automatic logic [31:0] store_lanes(input logic [31:0] old, input width_e width,
                                                input logic [1:0] lo, input logic [31:0] d);
        logic [31:0] w;
        w = old;
        case (width)
            width_byte: w[8*lo +: 8] = d[7:0];
            width_half: begin
                if (lo[1])
                    w[31:16] = d[15:0];
                else
                    w[15:0] = d[15:0];
            end
            default: w = d;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] w, input width_e width,
                                                input logic [1:0] lo, input logic sign);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*lo +: 8];
        h = lo[1] ? w[31:16] : w[15:0];
        case (width)
            width_byte: return sign ? {{24{b[7]}}, b} : {24'd0, b};
            width_half: return sign ? {{16{h[15]}}, h} : {16'd0, h};
            default:    return w;
        endcase
    endfunction

    // memory op with a random base, imm chosen so base + imm hits addr
    function automatic exe_mem_t mem_op(input logic write, input logic atom, input logic sign,
                                        input width_e width, input logic [31:0] addr,
                                        input logic [31:0] wdata, input logic [exp_w-1:0] exp);
        exe_mem_t op;
        logic [31:0] r;
        r        = next_rand();
        op.en    = 1'b1;
        op.write = write;
        op.atom  = atom;
        op.sign  = sign;
        op.width = width;
        op.base  = r;
        op.imm   = addr - r;
        r        = next_rand();
        op.rd    = r[4:0] | 5'd1;
        op.wdata = wdata;
        op.exp   = exp;
        return op;
    endfunction

    function automatic exe_mem_t plain_op(input logic [rd_w-1:0] rd, input logic [exp_w-1:0] exp);
        exe_mem_t op;
        op       = '0;
        op.rd    = rd;
        op.base  = next_rand();
        op.imm   = next_rand();
        op.wdata = next_rand();
        op.exp   = exp;
        return op;
    endfunction

    // queues the op and runs it through the model in issue order
    function automatic void add_op(input exe_mem_t op);
        logic [31:0]       addr;
        logic [ram_aw-1:0] idx;
        logic [1:0]        lo;
        logic              ok;
        exp_rec_t          rec;
        addr = op.base + op.imm;
        idx  = addr[ram_aw+1:2];
        lo   = addr[1:0];
        rec  = '0;
        ops_q.push_back(op);
        if (op.en || op.rd != '0) begin
            rec.wb.valid = 1'b1;
            rec.wb.exp   = op.exp;
            if (op.en && ((op.width == width_half && addr[0]) ||
                          (op.width == width_word && lo != 2'b00))) begin
                rec.wb.exp[exp_ale] = 1'b1;         // not executed
                rec.wb.badv         = addr;
            end else if (op.en) begin
                rec.stalls = {1'b0, addr[3:2]};
                if (op.write && op.atom) begin
                    ok = resv_v && (resv_idx == idx);
                    if (ok)
                        model_mem[idx] = store_lanes(model_mem[idx], op.width, lo, op.wdata);
                    resv_v      = 1'b0;
                    rec.wb.data = {31'd0, ok};
                end else if (op.write) begin
                    model_mem[idx] = store_lanes(model_mem[idx], op.width, lo, op.wdata);
                    if (idx == resv_idx)
                        resv_v = 1'b0;
                end else begin
                    rec.wb.data = extend_load(model_mem[idx], op.width, lo, op.sign);
                    if (op.atom) begin
                        resv_v   = 1'b1;
                        resv_idx = idx;
                    end
                end
            end
            rec.wb.rd = (rec.wb.exp != '0) ? '0 : op.rd;
            exp_q.push_back(rec);
        end
    endfunction

    function automatic void build_ops();
        logic [31:0] r;
        logic [31:0] a;
        for (int i = 0; i < ram_words; i++) begin
            a = i * 4;
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_word, a, fill_word(a), '0));
        end
        repeat (16) begin
            r = next_rand();
            a = {r[31:2], 2'b00};
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_word, a, next_rand(), '0));
            add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
        end
        // one byte or half written, the rest of the word read back
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            a = {r[31:2], 2'b00};
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_byte, a + k % 4, next_rand(), '0));
            add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
            for (int l = 0; l < 4; l++) begin
                add_op(mem_op(1'b0, 1'b0, 1'b0, width_byte, a + l, '0, '0));
                add_op(mem_op(1'b0, 1'b0, 1'b1, width_byte, a + l, '0, '0));
            end
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_half, a + 2 * (k % 2), next_rand(), '0));
            for (int l = 0; l < 4; l += 2) begin
                add_op(mem_op(1'b0, 1'b0, 1'b0, width_half, a + l, '0, '0));
                add_op(mem_op(1'b0, 1'b0, 1'b1, width_half, a + l, '0, '0));
            end
            add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
        end
        repeat (4) begin
            r = next_rand();
            a = {r[31:2], 2'b00};
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_half, a + 1, next_rand(), '0));
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_half, a + 3, next_rand(), '0));
            add_op(mem_op(1'b0, 1'b0, 1'b1, width_half, a + 1, '0, '0));
            for (int l = 1; l < 4; l++) begin
                add_op(mem_op(1'b1, 1'b0, 1'b0, width_word, a + l, next_rand(), '0));
                add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a + l, '0, '0));
            end
            add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
        end
        repeat (3) begin
            r = next_rand();
            a = {r[31:2], 2'b00};
            add_op(mem_op(1'b0, 1'b1, 1'b0, width_word, a, '0, '0));            // ll
            add_op(mem_op(1'b1, 1'b1, 1'b0, width_word, a, next_rand(), '0));   // sc ok
            add_op(mem_op(1'b1, 1'b1, 1'b0, width_word, a, next_rand(), '0));   // no ll
            add_op(mem_op(1'b0, 1'b1, 1'b0, width_word, a, '0, '0));
            add_op(mem_op(1'b1, 1'b0, 1'b0, width_word, a, next_rand(), '0));
            add_op(mem_op(1'b1, 1'b1, 1'b0, width_word, a, next_rand(), '0));   // lost
            add_op(mem_op(1'b0, 1'b1, 1'b0, width_word, a, '0, '0));
            add_op(mem_op(1'b0, 1'b1, 1'b0, width_word, a ^ 32'h40, '0, '0));   // moves it
            add_op(mem_op(1'b1, 1'b1, 1'b0, width_word, a, next_rand(), '0));
            add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
        end
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            add_op(plain_op(r[4:0] | 5'd1, k[0] ? r[11:5] : '0));
            add_op(plain_op('0, '0));                                           // bubble
        end
        r = next_rand();
        a = {r[31:2], 2'b00};
        add_op(mem_op(1'b0, 1'b0, 1'b1, width_byte, a + 3, '0, 7'b0000001));
        add_op(mem_op(1'b1, 1'b0, 1'b0, width_word, a, next_rand(), 7'b0000010));
        add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a + 2, '0, 7'b1000000));
        add_op(mem_op(1'b0, 1'b0, 1'b0, width_word, a, '0, '0));
    endfunction

    task automatic report_value(input string name, input logic [31:0] expv,
                                input logic [31:0] got);
        $display("Error at %0t: %s expected %h, got %h", $time, name, expv, got);
        errors++;
    endtask

    initial begin
        rst         = 1'b1;
        exe         = '0;
        lcg_state   = 32'h757e1c91;
        resv_v      = 1'b0;
        resv_idx    = '0;
        exp_head    = '0;
        head_ok     = 1'b0;
        wb_seen     = '0;
        stall_seen  = 1'b0;
        stall_cnt   = '0;
        seen_stalls = '0;
        started     = 1'b0;
        errors      = 0;
        wb_count    = 0;
        build_ops();
        limit = 4 * ops_q.size() + 100;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);      // stage idle after reset
        while (ops_q.size() != 0) begin
            if (!stall) begin
                exe     = ops_q.pop_front();
                started = 1'b1;
            end
            @(negedge clk);
        end
        while (stall) begin
            @(negedge clk);
        end
        exe = '0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_q.size());
            errors++;
        end
        $display("Writebacks checked: %0d, errors: %0d", wb_count, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run went past %0d cycles", limit);
            $display("Writebacks checked: %0d, errors: %0d", wb_count, errors);
            $display("Verification failed");
            $finish;
        end
    end

    // wb and stall as they stand at the falling edge
    always @(negedge clk) begin
        wb_seen    = wb;
        stall_seen = stall;
        if (!rst && wb.valid) begin
            head_ok = (exp_q.size() != 0);
            if (head_ok) begin
                exp_head = exp_q.pop_front();
                wb_count++;
            end else begin
                $display("Writeback at %0t with no op left to complete", $time);
                errors++;
            end
            seen_stalls = stall_cnt;
            stall_cnt   = '0;
        end else if (!rst && stall) begin
            stall_cnt = stall_cnt + 3'd1;
        end
    end

    assign checking = wb_seen.valid && head_ok;

    assert property (@(posedge clk) disable iff (rst)
        checking |-> wb_seen.rd == exp_head.wb.rd)
        else report_value("wb.rd", 32'(exp_head.wb.rd), 32'(wb_seen.rd));
    assert property (@(posedge clk) disable iff (rst)
        checking |-> wb_seen.data == exp_head.wb.data)
        else report_value("wb.data", exp_head.wb.data, wb_seen.data);
    assert property (@(posedge clk) disable iff (rst)
        checking |-> wb_seen.exp == exp_head.wb.exp)
        else report_value("wb.exp", 32'(exp_head.wb.exp), 32'(wb_seen.exp));
    assert property (@(posedge clk) disable iff (rst)
        checking |-> wb_seen.badv == exp_head.wb.badv)
        else report_value("wb.badv", exp_head.wb.badv, wb_seen.badv);
    // latency seen through the stall
    assert property (@(posedge clk) disable iff (rst)
        checking |-> seen_stalls == exp_head.stalls)
        else report_value("stall cycles", 32'(exp_head.stalls), 32'(seen_stalls));
    assert property (@(posedge clk) disable iff (rst)
        !started |-> !wb_seen.valid && !stall_seen)
        else begin
            $display("wb.valid or stall came up at %0t before any op was applied", $time);
            errors++;
        end

endmodule

//--- sim.f
rtl/mem_pkg.sv
rtl/load_align.sv
rtl/mem_request.sv
rtl/data_ram.sv
rtl/mem_response.sv
rtl/mem_stage_top.sv
testbench/tb_mem_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_stage
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
